/* Makefile */
# Verilator build and run for the galivan board testbench

VERILATOR ?= verilator
TOP       ?= galivan_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  := ALL CHECKS PASSED
SOURCES   := $(wildcard logic/*.sv) $(wildcard test/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation did not pass"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* logic/audio_io.sv */
// audio cpu glue
// memory decode with audio ram and external rom, sound latch read and
// clear, fm chip select, two dac registers, the output mixer and the
// periodic audio interrupt
`timescale 1ns/10ps

module audio_io (
  input  logic               clk_sys,
  input  logic               reset,
  input  galivan_pkg::addr_t addr,
  input  galivan_pkg::byte_t dout,
  input  logic               iorq_n,
  input  logic               m1_n,
  input  logic               mreq_n,
  input  logic               wr_n,
  input  logic               rfsh_n,
  input  galivan_pkg::byte_t snd_latch,
  input  galivan_pkg::byte_t rom_q,
  input  logic [15:0]        opl_sound,
  output galivan_pkg::byte_t din,
  output logic               latch_clr,
  output logic               rom_cs,
  output galivan_pkg::addr_t rom_addr,
  output logic               int_n,
  output logic               opl_cs,
  output logic               opl_a0,
  output logic [15:0]        sound
);

  // ====================
  // memory decode
  // ====================
  logic rom_en;
  logic ram_en;

  assign rom_en = iorq_n & (addr < galivan_pkg::AUDIO_RAM_BASE);
  assign ram_en = iorq_n & (addr >= galivan_pkg::AUDIO_RAM_BASE);

  assign rom_cs   = rom_en & rfsh_n & ~mreq_n;
  assign rom_addr = addr;

  galivan_pkg::byte_t ram [0:(2**galivan_pkg::AUDIO_RAM_AW)-1];
  galivan_pkg::byte_t ram_q;

  always_ff @(posedge clk_sys) begin
    if (~wr_n & ram_en) begin
      ram[addr[galivan_pkg::AUDIO_RAM_AW-1:0]] <= dout;
    end
    ram_q <= ram[addr[galivan_pkg::AUDIO_RAM_AW-1:0]];
  end

  // ====================
  // i/o decode
  // ====================
  galivan_pkg::audio_port_e port;
  logic                     io_cyc;
  logic                     latch_cs;

  assign port     = galivan_pkg::audio_port_e'(addr[7:0]);
  assign io_cyc   = ~iorq_n & m1_n;
  assign latch_cs = io_cyc & (port == galivan_pkg::PORT_LATCH_RD);

  // fm chip sits on ports 0 and 1, a0 picks address or data
  assign opl_cs = io_cyc & ((port == galivan_pkg::PORT_OPL_ADDR) |
                            (port == galivan_pkg::PORT_OPL_DATA));
  assign opl_a0 = addr[0];

  galivan_pkg::byte_t dac1;
  galivan_pkg::byte_t dac2;

  always_ff @(posedge clk_sys) begin
    if (reset) begin
      dac1      <= '0;
      dac2      <= '0;
      latch_clr <= 1'b0;
    end else begin
      latch_clr <= 1'b0;
      if (io_cyc & ~wr_n) begin
        case (port)
          galivan_pkg::PORT_DAC1:      dac1      <= dout;
          galivan_pkg::PORT_DAC2:      dac2      <= dout;
          galivan_pkg::PORT_LATCH_CLR: latch_clr <= 1'b1;
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    if (latch_cs) begin
      din = snd_latch;
    end else if (ram_en) begin
      din = ram_q;
    end else if (rom_en) begin
      din = rom_q;
    end else begin
      din = galivan_pkg::AUDIO_OPEN_BUS;
    end
  end

  // mixer, sum wraps at 16 bits
  assign sound = opl_sound + (16'(dac1) << galivan_pkg::DAC_SHIFT) +
                 (16'(dac2) << galivan_pkg::DAC_SHIFT);

  // ====================
  // timed interrupt
  // ====================
  logic [galivan_pkg::AUDIO_IRQ_CNT_W-1:0] irq_cnt;
  logic                                    irq_tick;

  assign irq_tick = (irq_cnt ==
                     galivan_pkg::AUDIO_IRQ_CNT_W'(galivan_pkg::AUDIO_IRQ_PERIOD - 1));

  always_ff @(posedge clk_sys) begin
    if (reset) begin
      irq_cnt <= '0;
      int_n   <= 1'b1;
    end else begin
      irq_cnt <= irq_tick ? '0 : irq_cnt + 1'b1;
      if (irq_tick) begin
        int_n <= 1'b0;
      end
      if (~iorq_n & ~m1_n) begin
        int_n <= 1'b1;
      end
    end
  end

endmodule

/* logic/board_regs.sv */
// main i/o register block
// input port and id reads, rom bank and flip, scroll and layer
// registers, and the main to audio sound latch
`timescale 1ns/10ps

module board_regs (
  input  logic                 clk_sys,
  input  logic                 reset,
  main_bus_if.regs             bus,
  input  galivan_pkg::byte_t   j1,
  input  galivan_pkg::byte_t   j2,
  input  galivan_pkg::byte_t   p1,
  input  galivan_pkg::byte_t   p2,
  input  galivan_pkg::byte_t   system,
  input  logic                 latch_clr,
  output galivan_pkg::byte_t   io_data,
  output logic                 bank,
  output logic                 flip,
  output galivan_pkg::scroll_t scrollx,
  output galivan_pkg::scroll_t scrolly,
  output logic [2:0]           layers,
  output galivan_pkg::byte_t   snd_latch
);

  galivan_pkg::main_port_e port;
  logic                    io_cyc;
  logic                    io_rd;
  logic                    io_wr;

  assign port   = galivan_pkg::main_port_e'(bus.addr[7:0]);
  assign io_cyc = ~bus.iorq_n & bus.m1_n;
  assign io_rd  = io_cyc & bus.wr_n;
  assign io_wr  = io_cyc & ~bus.wr_n;

  // ====================
  // port reads
  // ====================
  always_ff @(posedge clk_sys) begin
    if (io_rd) begin
      case (port)
        galivan_pkg::PORT_IN_J1:  io_data <= j1;
        galivan_pkg::PORT_IN_J2:  io_data <= j2;
        galivan_pkg::PORT_IN_SYS: io_data <= system;
        galivan_pkg::PORT_IN_P1:  io_data <= p1;
        galivan_pkg::PORT_IN_P2:  io_data <= p2;
        galivan_pkg::PORT_ID:     io_data <= galivan_pkg::ID_BYTE;
        default: ;
      endcase
    end
  end

  // ====================
  // port writes
  // ====================
  always_ff @(posedge clk_sys) begin
    if (reset) begin
      bank      <= 1'b0;
      flip      <= 1'b0;
      scrollx   <= '0;
      scrolly   <= '0;
      layers    <= '0;
      snd_latch <= '0;
    end else begin
      // audio side clear, a write in the same cycle overrides it
      if (latch_clr) begin
        snd_latch <= '0;
      end
      if (io_wr) begin
        case (port)
          galivan_pkg::PORT_BANK_FLIP: begin
            bank <= bus.dout[7];
            flip <= bus.dout[2];
          end
          galivan_pkg::PORT_SCROLLX_LO: scrollx[7:0] <= bus.dout;
          galivan_pkg::PORT_LAYER_SCROLLX_HI: begin
            layers        <= bus.dout[7:5];
            scrollx[10:8] <= bus.dout[2:0];
          end
          galivan_pkg::PORT_SCROLLY_LO: scrolly[7:0]  <= bus.dout;
          galivan_pkg::PORT_SCROLLY_HI: scrolly[10:8] <= bus.dout[2:0];
          // data bits 6..0 move up one place, bit 0 is always set
          galivan_pkg::PORT_SND_LATCH: snd_latch <= {bus.dout[6:0], 1'b1};
          default: ;
        endcase
      end
    end
  end

endmodule

/* logic/galivan_board.sv */
// galivan board glue, top level
// main cpu bus gathered into one interface for the memory decoder and
// the register block, audio cpu handled by its own block
`timescale 1ns/10ps

module galivan_board (
  input  logic                 clk_sys,
  input  logic                 reset,
  // main cpu
  input  galivan_pkg::addr_t   mcpu_addr,
  input  galivan_pkg::byte_t   mcpu_dout,
  input  logic                 mcpu_iorq_n,
  input  logic                 mcpu_m1_n,
  input  logic                 mcpu_mreq_n,
  input  logic                 mcpu_wr_n,
  input  logic                 mcpu_rfsh_n,
  output galivan_pkg::byte_t   mcpu_din,
  output logic                 mcpu_int_n,
  output logic                 mcpu_rom_cs,
  output galivan_pkg::addr_t   mcpu_rom_addr,
  input  galivan_pkg::byte_t   mcpu_rom_q,
  // controls and video timing
  input  galivan_pkg::byte_t   j1,
  input  galivan_pkg::byte_t   j2,
  input  galivan_pkg::byte_t   p1,
  input  galivan_pkg::byte_t   p2,
  input  galivan_pkg::byte_t   system,
  input  logic                 vs,
  output logic                 flip,
  output galivan_pkg::scroll_t scrollx,
  output galivan_pkg::scroll_t scrolly,
  output logic [2:0]           layers,
  // audio cpu
  input  galivan_pkg::addr_t   acpu_addr,
  input  galivan_pkg::byte_t   acpu_dout,
  input  logic                 acpu_iorq_n,
  input  logic                 acpu_m1_n,
  input  logic                 acpu_mreq_n,
  input  logic                 acpu_wr_n,
  input  logic                 acpu_rfsh_n,
  output galivan_pkg::byte_t   acpu_din,
  output logic                 acpu_int_n,
  output logic                 acpu_rom_cs,
  output galivan_pkg::addr_t   acpu_rom_addr,
  input  galivan_pkg::byte_t   acpu_rom_q,
  // fm chip and sound out
  output logic                 opl_cs,
  output logic                 opl_a0,
  input  logic [15:0]          opl_sound,
  output logic [15:0]          sound
);

  main_bus_if mbus ();

  assign mbus.addr   = mcpu_addr;
  assign mbus.dout   = mcpu_dout;
  assign mbus.iorq_n = mcpu_iorq_n;
  assign mbus.m1_n   = mcpu_m1_n;
  assign mbus.mreq_n = mcpu_mreq_n;
  assign mbus.wr_n   = mcpu_wr_n;
  assign mbus.rfsh_n = mcpu_rfsh_n;

  logic               bank;
  galivan_pkg::byte_t io_data;
  galivan_pkg::byte_t snd_latch;
  logic               latch_clr;

  main_map u_main_map (
    .clk_sys  (clk_sys),
    .reset    (reset),
    .bus      (mbus.map),
    .vs       (vs),
    .bank     (bank),
    .io_data  (io_data),
    .rom_q    (mcpu_rom_q),
    .din      (mcpu_din),
    .rom_cs   (mcpu_rom_cs),
    .rom_addr (mcpu_rom_addr),
    .int_n    (mcpu_int_n)
  );

  board_regs u_board_regs (
    .clk_sys   (clk_sys),
    .reset     (reset),
    .bus       (mbus.regs),
    .j1        (j1),
    .j2        (j2),
    .p1        (p1),
    .p2        (p2),
    .system    (system),
    .latch_clr (latch_clr),
    .io_data   (io_data),
    .bank      (bank),
    .flip      (flip),
    .scrollx   (scrollx),
    .scrolly   (scrolly),
    .layers    (layers),
    .snd_latch (snd_latch)
  );

  audio_io u_audio_io (
    .clk_sys   (clk_sys),
    .reset     (reset),
    .addr      (acpu_addr),
    .dout      (acpu_dout),
    .iorq_n    (acpu_iorq_n),
    .m1_n      (acpu_m1_n),
    .mreq_n    (acpu_mreq_n),
    .wr_n      (acpu_wr_n),
    .rfsh_n    (acpu_rfsh_n),
    .snd_latch (snd_latch),
    .rom_q     (acpu_rom_q),
    .opl_sound (opl_sound),
    .din       (acpu_din),
    .latch_clr (latch_clr),
    .rom_cs    (acpu_rom_cs),
    .rom_addr  (acpu_rom_addr),
    .int_n     (acpu_int_n),
    .opl_cs    (opl_cs),
    .opl_a0    (opl_a0),
    .sound     (sound)
  );

endmodule

/* logic/galivan_pkg.sv */
// galivan board package
// shared types, memory-map bounds, I/O port numbers and timing constants
// for the main and audio CPU glue logic
package galivan_pkg;

  // ====================
  // basic types
  // ====================
  typedef logic [15:0] addr_t;
  typedef logic [7:0]  byte_t;
  typedef logic [10:0] scroll_t;

  // ====================
  // main cpu memory map
  // ====================
  // rom below the bank window, sprite hole above it, work ram at the top
  localparam addr_t MAIN_BANK_BASE = 16'hc000;
  localparam addr_t MAIN_BANK_END  = 16'he000;
  localparam addr_t MAIN_SPR_END   = 16'he100;
  localparam int    MAIN_RAM_AW    = 13;

  // upper rom address bits that select each bank page
  localparam logic [2:0] BANK_PAGE0 = 3'b110;
  localparam logic [2:0] BANK_PAGE1 = 3'b111;

  localparam byte_t ID_BYTE = 8'h58;

  // ====================
  // audio cpu
  // ====================
  localparam addr_t AUDIO_RAM_BASE   = 16'hc000;
  localparam int    AUDIO_RAM_AW     = 11;
  // rst 38h opcode on an undriven read
  localparam byte_t AUDIO_OPEN_BUS   = 8'hff;
  localparam int    DAC_SHIFT        = 5;
  localparam int    AUDIO_IRQ_PERIOD = 6400;
  localparam int    AUDIO_IRQ_CNT_W  = $clog2(AUDIO_IRQ_PERIOD);

  // main cpu i/o ports
  typedef enum logic [7:0] {
    PORT_IN_J1            = 8'h00,
    PORT_IN_J2            = 8'h01,
    PORT_IN_SYS           = 8'h02,
    PORT_IN_P1            = 8'h03,
    PORT_IN_P2            = 8'h04,
    PORT_BANK_FLIP        = 8'h40,
    PORT_SCROLLX_LO       = 8'h41,
    PORT_LAYER_SCROLLX_HI = 8'h42,
    PORT_SCROLLY_LO       = 8'h43,
    PORT_SCROLLY_HI       = 8'h44,
    PORT_SND_LATCH        = 8'h45,
    PORT_ID               = 8'hc0
  } main_port_e;

  // audio cpu i/o ports
  typedef enum logic [7:0] {
    PORT_OPL_ADDR  = 8'h00,
    PORT_OPL_DATA  = 8'h01,
    PORT_DAC1      = 8'h02,
    PORT_DAC2      = 8'h03,
    PORT_LATCH_CLR = 8'h04,
    PORT_LATCH_RD  = 8'h06
  } audio_port_e;

endpackage

/* logic/main_bus_if.sv */
// main cpu bus
// address, write data and z80-style strobes shared by the memory
// decoder and the i/o register block
`timescale 1ns/10ps

interface main_bus_if;

  galivan_pkg::addr_t addr;
  galivan_pkg::byte_t dout;
  logic               iorq_n;
  logic               m1_n;
  logic               mreq_n;
  logic               wr_n;
  logic               rfsh_n;

  // memory decoder sees the whole bus
  modport map (
    input addr, dout, iorq_n, m1_n, mreq_n, wr_n, rfsh_n
  );

  // register block only needs i/o cycles
  modport regs (
    input addr, dout, iorq_n, m1_n, wr_n
  );

endinterface

/* logic/main_map.sv */
// main cpu memory map
// decodes rom, the banked rom window, the sprite hole and work ram,
// drives the external rom select and address, multiplexes read data
// and raises the vblank interrupt
`timescale 1ns/10ps

module main_map (
  input  logic               clk_sys,
  input  logic               reset,
  main_bus_if.map            bus,
  input  logic               vs,
  input  logic               bank,
  input  galivan_pkg::byte_t io_data,
  input  galivan_pkg::byte_t rom_q,
  output galivan_pkg::byte_t din,
  output logic               rom_cs,
  output galivan_pkg::addr_t rom_addr,
  output logic               int_n
);

  // ====================
  // address decode
  // ====================
  logic rom_en;
  logic bank_en;
  logic spr_en;
  logic ram_en;

  // memory regions only count outside i/o cycles
  assign rom_en  = bus.iorq_n & (bus.addr < galivan_pkg::MAIN_BANK_BASE);
  assign bank_en = bus.iorq_n & (bus.addr >= galivan_pkg::MAIN_BANK_BASE) &
                   (bus.addr < galivan_pkg::MAIN_BANK_END);
  assign spr_en  = bus.iorq_n & (bus.addr >= galivan_pkg::MAIN_BANK_END) &
                   (bus.addr < galivan_pkg::MAIN_SPR_END);
  assign ram_en  = bus.iorq_n & (bus.addr >= galivan_pkg::MAIN_SPR_END);

  // ====================
  // external rom
  // ====================
  logic [2:0] page_top;

  assign page_top = bank ? galivan_pkg::BANK_PAGE1 : galivan_pkg::BANK_PAGE0;

  assign rom_cs = (rom_en | bank_en) & bus.rfsh_n & ~bus.mreq_n;

  // bank window swaps in the page bits, everything else passes through
  assign rom_addr = bank_en ? {page_top, bus.addr[12:0]} : bus.addr;

  // ====================
  // work ram
  // ====================
  galivan_pkg::byte_t ram [0:(2**galivan_pkg::MAIN_RAM_AW)-1];
  galivan_pkg::byte_t ram_q;

  always_ff @(posedge clk_sys) begin
    if (~bus.wr_n & ram_en) begin
      ram[bus.addr[galivan_pkg::MAIN_RAM_AW-1:0]] <= bus.dout;
    end
    ram_q <= ram[bus.addr[galivan_pkg::MAIN_RAM_AW-1:0]];
  end

  // read data back to the cpu
  always_comb begin
    if (~bus.iorq_n) begin
      din = io_data;
    end else if (rom_en | bank_en) begin
      din = rom_q;
    end else if (spr_en) begin
      // sprite ram lives in the video block now
      din = '0;
    end else begin
      din = ram_q;
    end
  end

  // ====================
  // vblank interrupt
  // ====================
  logic vs_d;
  logic int_ack;

  assign int_ack = ~bus.iorq_n & ~bus.m1_n;

  always_ff @(posedge clk_sys) begin
    if (reset) begin
      vs_d  <= 1'b0;
      int_n <= 1'b1;
    end else begin
      vs_d <= vs;
      if (vs_d & ~vs) begin
        int_n <= 1'b0;
      end
      // acknowledge wins over a new edge in the same cycle
      if (int_ack) begin
        int_n <= 1'b1;
      end
    end
  end

endmodule

/* test/galivan_props.sv */
// galivan board checks
// bound into the board top level, tracks the expected register, ram and
// latch state from the bus traffic and checks the board outputs against it
`timescale 1ns/10ps

module galivan_props (
  input logic               clk_sys,
  input logic               reset,
  input galivan_pkg::addr_t mcpu_addr,
  input galivan_pkg::byte_t mcpu_dout,
  input logic               mcpu_iorq_n, mcpu_m1_n, mcpu_mreq_n, mcpu_wr_n, mcpu_rfsh_n,
  input galivan_pkg::byte_t mcpu_din,
  input logic               mcpu_int_n,
  input logic               mcpu_rom_cs,
  input galivan_pkg::addr_t mcpu_rom_addr,
  input galivan_pkg::byte_t mcpu_rom_q,
  input galivan_pkg::byte_t j1, j2, p1, p2, system,
  input logic               vs,
  input logic               flip,
  input galivan_pkg::scroll_t scrollx, scrolly,
  input logic [2:0]         layers,
  input galivan_pkg::addr_t acpu_addr,
  input galivan_pkg::byte_t acpu_dout,
  input logic               acpu_iorq_n, acpu_m1_n, acpu_mreq_n, acpu_wr_n, acpu_rfsh_n,
  input galivan_pkg::byte_t acpu_din,
  input logic               acpu_int_n,
  input logic               acpu_rom_cs,
  input galivan_pkg::addr_t acpu_rom_addr,
  input galivan_pkg::byte_t acpu_rom_q,
  input logic               opl_cs, opl_a0,
  input logic [15:0]        opl_sound,
  input logic [15:0]        sound
);

  int errors = 0;

  // ====================
  // bus cycle decode
  // ====================
  logic m_io_rd, m_io_wr, m_ack, ram_rd, ram_wr, spr_rd, rom_rd;
  logic a_io_rd, a_io_wr, a_ack, a_rom, aint_fall;
  galivan_pkg::addr_t rom_exp;
  galivan_pkg::byte_t port_val;
  logic               port_hit;

  assign m_io_rd = ~mcpu_iorq_n & mcpu_m1_n & mcpu_wr_n;
  assign m_io_wr = ~mcpu_iorq_n & mcpu_m1_n & ~mcpu_wr_n;
  assign m_ack   = ~mcpu_iorq_n & ~mcpu_m1_n;
  assign ram_wr  = mcpu_iorq_n & ~mcpu_wr_n & (mcpu_addr >= 16'he100);
  assign ram_rd  = mcpu_iorq_n & ~mcpu_mreq_n & mcpu_wr_n & (mcpu_addr >= 16'he100);
  assign spr_rd  = mcpu_iorq_n & ~mcpu_mreq_n & (mcpu_addr >= 16'he000) &
                   (mcpu_addr < 16'he100);
  assign rom_rd  = mcpu_iorq_n & ~mcpu_mreq_n & mcpu_rfsh_n & (mcpu_addr < 16'he000);
  assign a_io_rd = ~acpu_iorq_n & acpu_m1_n & acpu_wr_n;
  assign a_io_wr = ~acpu_iorq_n & acpu_m1_n & ~acpu_wr_n;
  assign a_ack   = ~acpu_iorq_n & ~acpu_m1_n;
  assign a_rom   = acpu_iorq_n & ~acpu_mreq_n & acpu_rfsh_n & (acpu_addr < 16'hc000);

  // expected main i/o read value for the addressed port
  always_comb begin
    port_hit = 1'b1;
    port_val = 8'h00;
    case (mcpu_addr[7:0])
      8'h00: port_val = j1;
      8'h01: port_val = j2;
      8'h02: port_val = system;
      8'h03: port_val = p1;
      8'h04: port_val = p2;
      8'hc0: port_val = 8'h58;
      default: port_hit = 1'b0;
    endcase
  end

  // ====================
  // expected state
  // ====================
  galivan_pkg::byte_t   shadow [0:8191];
  galivan_pkg::byte_t   ram_exp, io_exp, latch_m, dac1_m, dac2_m;
  logic                 io_known, bank_m, flip_m, clr_m, aint_d, seen;
  galivan_pkg::scroll_t sx_m, sy_m;
  logic [2:0]           lay_m;
  int                   since;

  assign rom_exp   = (mcpu_addr >= 16'hc000) ?
                     {(bank_m ? 3'b111 : 3'b110), mcpu_addr[12:0]} : mcpu_addr;
  assign aint_fall = aint_d & ~acpu_int_n;

  always_ff @(posedge clk_sys) begin
    if (ram_wr) begin
      shadow[mcpu_addr[12:0]] <= mcpu_dout;
    end
    ram_exp  <= shadow[mcpu_addr[12:0]];
    io_exp   <= port_val;
    io_known <= m_io_rd & port_hit;
    aint_d   <= acpu_int_n;
    if (reset) begin
      bank_m  <= 1'b0;
      flip_m  <= 1'b0;
      sx_m    <= '0;
      sy_m    <= '0;
      lay_m   <= '0;
      latch_m <= '0;
      dac1_m  <= '0;
      dac2_m  <= '0;
      clr_m   <= 1'b0;
      seen    <= 1'b0;
      since   <= 0;
    end else begin
      clr_m <= a_io_wr & (acpu_addr[7:0] == 8'h04);
      if (clr_m) begin
        latch_m <= '0;
      end
      // main writes come after the clear so they take priority
      if (m_io_wr) begin
        case (mcpu_addr[7:0])
          8'h40: begin
            bank_m <= mcpu_dout[7];
            flip_m <= mcpu_dout[2];
          end
          8'h41: sx_m[7:0] <= mcpu_dout;
          8'h42: begin
            lay_m      <= mcpu_dout[7:5];
            sx_m[10:8] <= mcpu_dout[2:0];
          end
          8'h43: sy_m[7:0]  <= mcpu_dout;
          8'h44: sy_m[10:8] <= mcpu_dout[2:0];
          8'h45: latch_m    <= {mcpu_dout[6:0], 1'b1};
          default: ;
        endcase
      end
      if (a_io_wr & (acpu_addr[7:0] == 8'h02)) begin
        dac1_m <= acpu_dout;
      end
      if (a_io_wr & (acpu_addr[7:0] == 8'h03)) begin
        dac2_m <= acpu_dout;
      end
      since <= aint_fall ? 1 : since + 1;
      if (aint_fall) begin
        seen <= 1'b1;
      end
    end
  end

  // ====================
  // checks
  // ====================
  ram_readback: assert property (@(posedge clk_sys) disable iff (reset)
    ram_rd && $past(ram_rd) && $stable(mcpu_addr) |-> mcpu_din == ram_exp)
    else begin
      errors++;
      $error("FAIL %0t: work ram at %h read %h, expected %h", $time, mcpu_addr,
             mcpu_din, ram_exp);
    end

  hole_zero: assert property (@(posedge clk_sys) disable iff (reset)
    spr_rd |-> mcpu_din == 8'h00)
    else begin
      errors++;
      $error("FAIL %0t: sprite hole at %h read %h", $time, mcpu_addr, mcpu_din);
    end

  port_read: assert property (@(posedge clk_sys) disable iff (reset)
    m_io_rd && io_known && $stable(mcpu_addr) |-> mcpu_din == io_exp)
    else begin
      errors++;
      $error("FAIL %0t: main port %h read %h, expected %h", $time, mcpu_addr[7:0],
             mcpu_din, io_exp);
    end

  rom_select: assert property (@(posedge clk_sys) disable iff (reset)
    rom_rd |-> mcpu_rom_cs && (mcpu_rom_addr == rom_exp) && (mcpu_din == mcpu_rom_q))
    else begin
      errors++;
      $error("FAIL %0t: rom access at %h gave addr %h data %h, expected %h and %h", $time,
             mcpu_addr, mcpu_rom_addr, mcpu_din, rom_exp, mcpu_rom_q);
    end

  video_regs: assert property (@(posedge clk_sys) disable iff (reset)
    flip == flip_m && scrollx == sx_m && scrolly == sy_m && layers == lay_m)
    else begin
      errors++;
      $error("FAIL %0t: flip, scroll or layer output differs from last write", $time);
    end

  latch_read: assert property (@(posedge clk_sys) disable iff (reset)
    a_io_rd && acpu_addr[7:0] == 8'h06 |-> acpu_din == latch_m)
    else begin
      errors++;
      $error("FAIL %0t: sound latch read %h, expected %h", $time, acpu_din, latch_m);
    end

  open_bus: assert property (@(posedge clk_sys) disable iff (reset)
    a_io_rd && acpu_addr[7:0] != 8'h06 |-> acpu_din == 8'hff)
    else begin
      errors++;
      $error("FAIL %0t: audio port %h read %h", $time, acpu_addr[7:0], acpu_din);
    end

  // fm chip on ports 0 and 1, port 1 is the data port
  fm_select: assert property (@(posedge clk_sys) disable iff (reset)
    opl_cs == ((a_io_rd || a_io_wr) && acpu_addr[7:0] < 8'h02) &&
    (!opl_cs || opl_a0 == (acpu_addr[7:0] == 8'h01)))
    else begin
      errors++;
      $error("FAIL %0t: fm select %b a0 %b at audio port %h", $time, opl_cs, opl_a0,
             acpu_addr[7:0]);
    end

  audio_rom: assert property (@(posedge clk_sys) disable iff (reset)
    acpu_rom_cs == a_rom &&
    (!a_rom || (acpu_rom_addr == acpu_addr && acpu_din == acpu_rom_q)))
    else begin
      errors++;
      $error("FAIL %0t: audio rom at %h gave cs %b addr %h data %h", $time, acpu_addr,
             acpu_rom_cs, acpu_rom_addr, acpu_din);
    end

  mixer_sum: assert property (@(posedge clk_sys) disable iff (reset)
    sound == opl_sound + {3'b000, dac1_m, 5'b00000} + {3'b000, dac2_m, 5'b00000})
    else begin
      errors++;
      $error("FAIL %0t: sound %h does not match fm plus dac sum", $time, sound);
    end

  vblank_int: assert property (@(posedge clk_sys) disable iff (reset)
    $fell(vs) |=> !mcpu_int_n)
    else begin
      errors++;
      $error("FAIL %0t: main interrupt missing after vblank", $time);
    end

  main_ack: assert property (@(posedge clk_sys) disable iff (reset)
    m_ack |=> mcpu_int_n)
    else begin
      errors++;
      $error("FAIL %0t: main interrupt still low after acknowledge", $time);
    end

  audio_ack: assert property (@(posedge clk_sys) disable iff (reset)
    a_ack |=> acpu_int_n)
    else begin
      errors++;
      $error("FAIL %0t: audio interrupt still low after acknowledge", $time);
    end

  audio_period: assert property (@(posedge clk_sys) disable iff (reset)
    aint_fall && seen |-> since == galivan_pkg::AUDIO_IRQ_PERIOD)
    else begin
      errors++;
      $error("FAIL %0t: audio interrupt interval %0d clocks", $time, since);
    end

endmodule

/* test/galivan_tb.sv */
// galivan board testbench
// drives both cpu buses through memory, i/o and interrupt cycles,
// the bound property module does the checking
`timescale 1ns/10ps

module galivan_tb;

  localparam int CLK_PERIOD  = 100;
  localparam int SEED        = 77609;
  // short bus tests plus three audio interrupt periods
  localparam int TEST_CYCLES = 600 + 3 * galivan_pkg::AUDIO_IRQ_PERIOD;
  localparam int MARGIN      = 1000;

  logic                 clk_sys;
  logic                 reset;
  galivan_pkg::addr_t   mcpu_addr, mcpu_rom_addr, acpu_addr, acpu_rom_addr;
  galivan_pkg::byte_t   mcpu_dout, mcpu_din, mcpu_rom_q, acpu_dout, acpu_din, acpu_rom_q;
  logic                 mcpu_iorq_n, mcpu_m1_n, mcpu_mreq_n, mcpu_wr_n, mcpu_rfsh_n;
  logic                 acpu_iorq_n, acpu_m1_n, acpu_mreq_n, acpu_wr_n, acpu_rfsh_n;
  logic                 mcpu_int_n, mcpu_rom_cs, acpu_int_n, acpu_rom_cs;
  galivan_pkg::byte_t   j1, j2, p1, p2, system;
  logic                 vs, flip, opl_cs, opl_a0;
  galivan_pkg::scroll_t scrollx, scrolly;
  logic [2:0]           layers;
  logic [15:0]          opl_sound, sound;

  int wait_fails = 0;
  int n_tests    = 0;
  int bad_tests  = 0;
  int mark       = 0;

  galivan_board dut (.*);

  bind galivan_board galivan_props u_props (.*);

  initial begin
    clk_sys = 1'b0;
    forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
  end

  // watchdog
  initial begin
    #((TEST_CYCLES + MARGIN) * CLK_PERIOD);
    $display("timeout: run did not finish within %0d clocks", TEST_CYCLES + MARGIN);
    $display("CHECKS FAILED");
    $finish;
  end

  function automatic int failed_checks();
    return dut.u_props.errors + wait_fails;
  endfunction

  function automatic galivan_pkg::addr_t io_addr(input galivan_pkg::byte_t port);
    return {8'h00, port};
  endfunction

  // ====================
  // bus cycles
  // ====================
  task automatic main_cycle(input galivan_pkg::addr_t a, input galivan_pkg::byte_t d,
                            input logic io, input logic wr, input int len);
    @(negedge clk_sys);
    mcpu_addr   = a;
    mcpu_dout   = d;
    mcpu_iorq_n = ~io;
    mcpu_mreq_n = io;
    mcpu_wr_n   = ~wr;
    repeat (len) @(negedge clk_sys);
    mcpu_iorq_n = 1'b1;
    mcpu_mreq_n = 1'b1;
    mcpu_wr_n   = 1'b1;
  endtask

  task automatic audio_cycle(input galivan_pkg::addr_t a, input galivan_pkg::byte_t d,
                             input logic io, input logic wr, input int len);
    @(negedge clk_sys);
    acpu_addr   = a;
    acpu_dout   = d;
    acpu_iorq_n = ~io;
    acpu_mreq_n = io;
    acpu_wr_n   = ~wr;
    repeat (len) @(negedge clk_sys);
    acpu_iorq_n = 1'b1;
    acpu_mreq_n = 1'b1;
    acpu_wr_n   = 1'b1;
  endtask

  // interrupt acknowledge, iorq and m1 low together for one clock
  task automatic int_ack(input logic audio);
    @(negedge clk_sys);
    if (audio) begin
      acpu_iorq_n = 1'b0;
      acpu_m1_n   = 1'b0;
    end else begin
      mcpu_iorq_n = 1'b0;
      mcpu_m1_n   = 1'b0;
    end
    @(negedge clk_sys);
    acpu_iorq_n = 1'b1;
    acpu_m1_n   = 1'b1;
    mcpu_iorq_n = 1'b1;
    mcpu_m1_n   = 1'b1;
  endtask

  task automatic wait_int(input logic audio, input int limit);
    int n;
    n = 0;
    while ((audio ? acpu_int_n : mcpu_int_n) && n < limit) begin
      @(negedge clk_sys);
      n++;
    end
    if (n >= limit) begin
      wait_fails++;
      $display("%s cpu interrupt did not arrive within %0d clocks",
               audio ? "audio" : "main", limit);
    end
  endtask

  task automatic finish_test(input string name);
    int errs;
    repeat (2) @(negedge clk_sys);
    errs = failed_checks() - mark;
    mark = failed_checks();
    n_tests++;
    if (errs == 0) begin
      $display("PASS %s", name);
    end else begin
      bad_tests++;
      $display("FAIL %0t: %s had %0d failed checks", $time, name, errs);
    end
  endtask

  // ====================
  // test sequence
  // ====================
  initial begin
    galivan_pkg::addr_t a;
    galivan_pkg::byte_t d;
    galivan_pkg::byte_t in_ports [6];

    void'($urandom(SEED));
    in_ports = '{galivan_pkg::PORT_IN_J1, galivan_pkg::PORT_IN_J2, galivan_pkg::PORT_IN_SYS,
                 galivan_pkg::PORT_IN_P1, galivan_pkg::PORT_IN_P2, galivan_pkg::PORT_ID};
    reset       = 1'b1;
    mcpu_addr   = '0;
    mcpu_dout   = '0;
    mcpu_iorq_n = 1'b1;
    mcpu_m1_n   = 1'b1;
    mcpu_mreq_n = 1'b1;
    mcpu_wr_n   = 1'b1;
    mcpu_rfsh_n = 1'b1;
    mcpu_rom_q  = '0;
    acpu_addr   = '0;
    acpu_dout   = '0;
    acpu_iorq_n = 1'b1;
    acpu_m1_n   = 1'b1;
    acpu_mreq_n = 1'b1;
    acpu_wr_n   = 1'b1;
    acpu_rfsh_n = 1'b1;
    acpu_rom_q  = '0;
    j1          = '0;
    j2          = '0;
    p1          = '0;
    p2          = '0;
    system      = '0;
    vs          = 1'b1;
    opl_sound   = '0;
    repeat (3) @(posedge clk_sys);
    @(negedge clk_sys);
    reset = 1'b0;

    // work ram write and readback, then the sprite hole
    repeat (4) begin
      a = galivan_pkg::MAIN_SPR_END + 16'($urandom % 32'h1f00);
      d = 8'($urandom);
      main_cycle(a, d, 1'b0, 1'b1, 1);
      main_cycle(a, 8'h00, 1'b0, 1'b0, 2);
    end
    main_cycle(galivan_pkg::MAIN_BANK_END + 16'($urandom % 32'h100), 8'h00, 1'b0, 1'b0, 2);
    finish_test("work ram");

    @(negedge clk_sys);
    j1     = 8'($urandom);
    j2     = 8'($urandom);
    system = 8'($urandom);
    p1     = 8'($urandom);
    p2     = 8'($urandom);
    foreach (in_ports[i]) begin
      main_cycle(io_addr(in_ports[i]), 8'h00, 1'b1, 1'b0, 2);
    end
    finish_test("input ports");

    // both bank pages, then an unbanked rom access and the video registers
    mcpu_rom_q = 8'($urandom);
    main_cycle(io_addr(galivan_pkg::PORT_BANK_FLIP), 8'h84, 1'b1, 1'b1, 1);
    main_cycle(galivan_pkg::MAIN_BANK_BASE + 16'($urandom % 32'h2000), 8'h00, 1'b0, 1'b0, 1);
    main_cycle(io_addr(galivan_pkg::PORT_BANK_FLIP), 8'h00, 1'b1, 1'b1, 1);
    main_cycle(galivan_pkg::MAIN_BANK_BASE + 16'($urandom % 32'h2000), 8'h00, 1'b0, 1'b0, 1);
    main_cycle(16'($urandom % 32'hc000), 8'h00, 1'b0, 1'b0, 1);
    main_cycle(io_addr(galivan_pkg::PORT_SCROLLX_LO), 8'($urandom), 1'b1, 1'b1, 1);
    main_cycle(io_addr(galivan_pkg::PORT_LAYER_SCROLLX_HI), 8'($urandom), 1'b1, 1'b1, 1);
    main_cycle(io_addr(galivan_pkg::PORT_SCROLLY_LO), 8'($urandom), 1'b1, 1'b1, 1);
    main_cycle(io_addr(galivan_pkg::PORT_SCROLLY_HI), 8'($urandom), 1'b1, 1'b1, 1);
    finish_test("bank and scroll");

    main_cycle(io_addr(galivan_pkg::PORT_SND_LATCH), 8'($urandom), 1'b1, 1'b1, 1);
    audio_cycle(io_addr(galivan_pkg::PORT_LATCH_RD), 8'h00, 1'b1, 1'b0, 1);
    audio_cycle(io_addr(galivan_pkg::PORT_LATCH_CLR), 8'h00, 1'b1, 1'b1, 1);
    audio_cycle(io_addr(galivan_pkg::PORT_LATCH_RD), 8'h00, 1'b1, 1'b0, 1);
    finish_test("sound latch");

    @(negedge clk_sys);
    opl_sound = 16'($urandom);
    audio_cycle(io_addr(galivan_pkg::PORT_DAC1), 8'($urandom), 1'b1, 1'b1, 1);
    audio_cycle(io_addr(galivan_pkg::PORT_DAC2), 8'($urandom), 1'b1, 1'b1, 1);
    // fm chip ports and an audio rom fetch
    audio_cycle(io_addr(galivan_pkg::PORT_OPL_ADDR), 8'($urandom), 1'b1, 1'b1, 1);
    audio_cycle(io_addr(galivan_pkg::PORT_OPL_DATA), 8'($urandom), 1'b1, 1'b1, 1);
    acpu_rom_q = 8'($urandom);
    audio_cycle(16'($urandom % 32'hc000), 8'h00, 1'b0, 1'b0, 1);
    repeat (3) begin
      d = 8'($urandom);
      if (d == galivan_pkg::PORT_LATCH_RD) begin
        d = 8'h05;
      end
      audio_cycle(io_addr(d), 8'h00, 1'b1, 1'b0, 1);
    end
    finish_test("mixer and audio bus");

    @(negedge clk_sys);
    vs = 1'b0;
    wait_int(1'b0, 4);
    int_ack(1'b0);
    vs = 1'b1;
    finish_test("vblank interrupt");

    // three interrupts give two full intervals to measure
    repeat (3) begin
      wait_int(1'b1, galivan_pkg::AUDIO_IRQ_PERIOD + 10);
      int_ack(1'b1);
    end
    finish_test("audio interrupt");

    $display("tests run %0d, tests failed %0d, failed checks %0d", n_tests, bad_tests,
             failed_checks());
    if (bad_tests == 0 && failed_checks() == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* vlog.f */
logic/galivan_pkg.sv
logic/main_bus_if.sv
logic/main_map.sv
logic/board_regs.sv
logic/audio_io.sv
logic/galivan_board.sv
test/galivan_props.sv
test/galivan_tb.sv
